/* Makefile */
# Verilator build and run for the execute stage
VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILELIST  ?= ncpu_ex.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

/* ex_add.sv */
// Shared execute adder
`timescale 1ns/1ps

module ex_add
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64
)
(
   ex_issue_if.add_mp            issue,
   output logic [CONFIG_DW-1:0]  add_sum,
   output logic                  add_carry,
   output logic                  add_overflow
);
   logic                  sub;
   logic                  bcc;
   logic [CONFIG_DW-1:0]  opd_b;

   // Every conditional branch compares by subtraction
   assign bcc = issue.ex_bru_opc[NCPU_BRU_BEQ] | issue.ex_bru_opc[NCPU_BRU_BNE] |
                issue.ex_bru_opc[NCPU_BRU_BGTU] | issue.ex_bru_opc[NCPU_BRU_BGT] |
                issue.ex_bru_opc[NCPU_BRU_BLEU] | issue.ex_bru_opc[NCPU_BRU_BLE];

   assign sub = bcc | issue.ex_alu_opc[NCPU_ALU_SUB];

   // Two's complement, invert and carry in
   assign opd_b = sub ? ~issue.ex_operand2 : issue.ex_operand2;

   // One extra bit for the carry out
   assign {add_carry, add_sum} = {1'b0, issue.ex_operand1} + {1'b0, opd_b} +
                                 {{CONFIG_DW{1'b0}}, sub};

   // Signed overflow
   // same input signs, sum sign differs
   assign add_overflow = (issue.ex_operand1[CONFIG_DW-1] == opd_b[CONFIG_DW-1]) &
                         (add_sum[CONFIG_DW-1] != issue.ex_operand1[CONFIG_DW-1]);

endmodule

/* ex_alu.sv */
// Integer logic and arithmetic unit
`timescale 1ns/1ps

module ex_alu
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64
)
(
   ex_issue_if.alu_mp            issue,
   // Sum or difference from the shared adder
   input  logic [CONFIG_DW-1:0]  add_sum,
   output logic [CONFIG_DW-1:0]  alu_dout
);
   logic                  sel_add;
   logic                  sel_and;
   logic                  sel_or;
   logic                  sel_xor;
   logic [CONFIG_DW-1:0]  res_and;
   logic [CONFIG_DW-1:0]  res_or;
   logic [CONFIG_DW-1:0]  res_xor;

   // Adder already knows add from sub
   assign sel_add = issue.ex_alu_opc[NCPU_ALU_ADD] | issue.ex_alu_opc[NCPU_ALU_SUB];
   assign sel_and = issue.ex_alu_opc[NCPU_ALU_AND];
   assign sel_or = issue.ex_alu_opc[NCPU_ALU_OR];
   assign sel_xor = issue.ex_alu_opc[NCPU_ALU_XOR];

   // Bitwise group
   assign res_and = issue.ex_operand1 & issue.ex_operand2;
   assign res_or = issue.ex_operand1 | issue.ex_operand2;
   assign res_xor = issue.ex_operand1 ^ issue.ex_operand2;

   // AND-OR select
   // zero when no opcode bit is set
   assign alu_dout = ({CONFIG_DW{sel_add}} & add_sum) |
                     ({CONFIG_DW{sel_and}} & res_and) |
                     ({CONFIG_DW{sel_or}} & res_or) |
                     ({CONFIG_DW{sel_xor}} & res_xor);

endmodule

/* ex_bru.sv */
// Branch resolution unit
`timescale 1ns/1ps

module ex_bru
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64,
   parameter int CONFIG_AW = 64,
   localparam int PC_W = CONFIG_AW - NCPU_P_INSN_LEN
)
(
   ex_issue_if.bru_mp            issue,
   // Flags from the shared adder
   input  logic [CONFIG_DW-1:0]  add_sum,
   input  logic                  add_carry,
   input  logic                  add_overflow,
   // Redirect
   output logic                  b_taken,
   output logic [PC_W-1:0]       b_tgt,
   // Link value
   output logic [CONFIG_DW-1:0]  bru_dout,
   output logic                  bru_dout_valid
);
   logic                  cmp_eq;
   logic                  cmp_lt_s;
   logic                  cmp_lt_u;
   logic                  cond_hit;
   logic                  jmp_reg;
   logic                  jmp_rel;
   logic [PC_W-1:0]       tgt_bcc;
   logic [PC_W-1:0]       tgt_rel;
   logic [PC_W-1:0]       tgt_reg;
   logic [CONFIG_AW-1:0]  lnk_addr;

   // Equality needs no adder
   assign cmp_eq = (issue.ex_operand1 == issue.ex_operand2);

   // Sign of difference, corrected for overflow
   assign cmp_lt_s = add_sum[CONFIG_DW-1] ^ add_overflow;
   // No borrow means op1 >= op2
   assign cmp_lt_u = ~add_carry;

   assign jmp_reg = issue.ex_bru_opc[NCPU_BRU_JMPREG];
   assign jmp_rel = issue.ex_bru_opc[NCPU_BRU_JMPREL];

   // Six conditions, one-hot
   always_comb begin
      cond_hit = 1'b0;
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BEQ] & cmp_eq;
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BNE] & ~cmp_eq;
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BGTU] & ~cmp_lt_u & ~cmp_eq;
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BGT] & ~cmp_lt_s & ~cmp_eq;
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BLEU] & (cmp_lt_u | cmp_eq);
      cond_hit |= issue.ex_bru_opc[NCPU_BRU_BLE] & (cmp_lt_s | cmp_eq);
   end

   assign b_taken = issue.ex_valid & (cond_hit | jmp_reg | jmp_rel);

   // Candidate targets, all in words
   assign tgt_bcc = issue.ex_pc + issue.ex_imm;
   assign tgt_rel = issue.ex_pc + issue.ex_operand2[CONFIG_AW-1:NCPU_P_INSN_LEN];
   // Low byte bits dropped, not checked
   assign tgt_reg = issue.ex_operand1[CONFIG_AW-1:NCPU_P_INSN_LEN];

   assign b_tgt = ({PC_W{cond_hit}} & tgt_bcc) |
                  ({PC_W{jmp_rel}} & tgt_rel) |
                  ({PC_W{jmp_reg}} & tgt_reg);

   // Return address as a byte address
   assign lnk_addr = {issue.npc, {NCPU_P_INSN_LEN{1'b0}}};
   assign bru_dout = CONFIG_DW'(lnk_addr);

   // Only jumps link
   assign bru_dout_valid = (jmp_reg | jmp_rel) & issue.ex_rf_we;

endmodule

/* ex_commit.sv */
// Execute stage output register
`timescale 1ns/1ps

module ex_commit
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64,
   parameter int CONFIG_AW = 64,
   localparam int PC_W = CONFIG_AW - NCPU_P_INSN_LEN
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Issue qualifiers
   input  logic                  ex_valid,
   input  logic                  ex_rf_we,
   // Branch unit
   input  logic                  b_taken,
   input  logic [PC_W-1:0]       b_tgt,
   input  logic [CONFIG_DW-1:0]  bru_dout,
   input  logic                  bru_dout_valid,
   // ALU
   input  logic [CONFIG_DW-1:0]  alu_dout,
   // Writeback
   output logic                  wb_we,
   output logic [CONFIG_DW-1:0]  wb_data,
   // Fetch redirect
   output logic                  redirect,
   output logic [PC_W-1:0]       redirect_tgt
);
   logic                  we_nxt;
   logic [CONFIG_DW-1:0]  data_nxt;

   // Write only for a live instruction
   assign we_nxt = ex_valid & ex_rf_we;

   // Link beats the ALU result
   assign data_nxt = bru_dout_valid ? bru_dout : alu_dout;

   // One-cycle stage latency
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_we <= 1'b0;
         wb_data <= '0;
         redirect <= 1'b0;
         redirect_tgt <= '0;
      end else begin
         wb_we <= we_nxt;
         wb_data <= data_nxt;
         // b_taken already carries ex_valid
         redirect <= b_taken;
         redirect_tgt <= b_tgt;
      end
   end

endmodule

/* ex_issue_if.sv */
// Execute issue bundle
`timescale 1ns/1ps

interface ex_issue_if
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64,
   parameter int CONFIG_AW = 64
);
   // Word address width
   localparam int PC_W = CONFIG_AW - NCPU_P_INSN_LEN;

   logic                  ex_valid;
   bru_opc_t              ex_bru_opc;
   alu_opc_t              ex_alu_opc;
   // PC and immediate are both in words
   logic [PC_W-1:0]       ex_pc;
   logic [PC_W-1:0]       ex_imm;
   logic [CONFIG_DW-1:0]  ex_operand1;
   logic [CONFIG_DW-1:0]  ex_operand2;
   logic                  ex_rf_we;
   // Next PC, return address for links
   logic [PC_W-1:0]       npc;

   // Adder picks add or sub from both opcodes
   modport add_mp (
      input ex_bru_opc, ex_alu_opc, ex_operand1, ex_operand2
   );

   // Branch unit sees nearly everything
   modport bru_mp (
      input ex_valid, ex_bru_opc, ex_pc, ex_imm, ex_operand1, ex_operand2,
      input ex_rf_we, npc
   );

   modport alu_mp (
      input ex_alu_opc, ex_operand1, ex_operand2
   );

endinterface

/* ex_top.sv */
// Execute stage top
`timescale 1ns/1ps

module ex_top
   import ncpu_ex_pkg::*;
#(
   parameter int CONFIG_DW = 64,
   parameter int CONFIG_AW = 64,
   localparam int PC_W = CONFIG_AW - NCPU_P_INSN_LEN
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   // Issued instruction
   input  logic                  ex_valid,
   input  bru_opc_t              ex_bru_opc,
   input  alu_opc_t              ex_alu_opc,
   input  logic [PC_W-1:0]       ex_pc,
   input  logic [PC_W-1:0]       ex_imm,
   input  logic [CONFIG_DW-1:0]  ex_operand1,
   input  logic [CONFIG_DW-1:0]  ex_operand2,
   input  logic                  ex_rf_we,
   input  logic [PC_W-1:0]       npc,
   // Registered results
   output logic                  wb_we,
   output logic [CONFIG_DW-1:0]  wb_data,
   output logic                  redirect,
   output logic [PC_W-1:0]       redirect_tgt
);
   logic [CONFIG_DW-1:0]  add_sum;
   logic                  add_carry;
   logic                  add_overflow;
   logic                  b_taken;
   logic [PC_W-1:0]       b_tgt;
   logic [CONFIG_DW-1:0]  bru_dout;
   logic                  bru_dout_valid;
   logic [CONFIG_DW-1:0]  alu_dout;

   // Issue bundle, fed straight from the ports
   ex_issue_if #(.CONFIG_DW(CONFIG_DW), .CONFIG_AW(CONFIG_AW)) issue_if ();

   assign issue_if.ex_valid = ex_valid;
   assign issue_if.ex_bru_opc = ex_bru_opc;
   assign issue_if.ex_alu_opc = ex_alu_opc;
   assign issue_if.ex_pc = ex_pc;
   assign issue_if.ex_imm = ex_imm;
   assign issue_if.ex_operand1 = ex_operand1;
   assign issue_if.ex_operand2 = ex_operand2;
   assign issue_if.ex_rf_we = ex_rf_we;
   assign issue_if.npc = npc;

   // One adder for ALU and branch compare
   ex_add #(.CONFIG_DW(CONFIG_DW)) add_inst (
      .issue         (issue_if.add_mp),
      .add_sum       (add_sum),
      .add_carry     (add_carry),
      .add_overflow  (add_overflow)
   );

   ex_bru #(.CONFIG_DW(CONFIG_DW), .CONFIG_AW(CONFIG_AW)) bru_inst (
      .issue           (issue_if.bru_mp),
      .add_sum         (add_sum),
      .add_carry       (add_carry),
      .add_overflow    (add_overflow),
      .b_taken         (b_taken),
      .b_tgt           (b_tgt),
      .bru_dout        (bru_dout),
      .bru_dout_valid  (bru_dout_valid)
   );

   ex_alu #(.CONFIG_DW(CONFIG_DW)) alu_inst (
      .issue     (issue_if.alu_mp),
      .add_sum   (add_sum),
      .alu_dout  (alu_dout)
   );

   // Valid and write enable bypass the bundle
   ex_commit #(.CONFIG_DW(CONFIG_DW), .CONFIG_AW(CONFIG_AW)) commit_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .ex_valid        (ex_valid),
      .ex_rf_we        (ex_rf_we),
      .b_taken         (b_taken),
      .b_tgt           (b_tgt),
      .bru_dout        (bru_dout),
      .bru_dout_valid  (bru_dout_valid),
      .alu_dout        (alu_dout),
      .wb_we           (wb_we),
      .wb_data         (wb_data),
      .redirect        (redirect),
      .redirect_tgt    (redirect_tgt)
   );

endmodule

/* ex_top_properties.sv */
// Execute stage output assertions
`timescale 1ns/1ps

module ex_top_properties (
   input logic clk,
   input logic rst_n,
   input logic ex_valid,
   input logic wb_we,
   input logic redirect
);
   // Reset clears both strobes by the next edge
   assert property (@(posedge clk) !rst_n |=> !wb_we && !redirect)
      else $error("wb_we or redirect set after a reset cycle");

   // Strobes always known out of reset
   assert property (@(posedge clk) rst_n |-> !$isunknown({wb_we, redirect}))
      else $error("wb_we or redirect unknown");

   // Redirect only follows a valid issue
   assert property (@(posedge clk) redirect |-> $past(ex_valid))
      else $error("redirect without a valid instruction");

endmodule

bind ex_top ex_top_properties props_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .ex_valid  (ex_valid),
   .wb_we     (wb_we),
   .redirect  (redirect)
);

/* ncpu_ex.f */
ncpu_ex_pkg.sv
ex_issue_if.sv
ex_add.sv
ex_bru.sv
ex_alu.sv
ex_commit.sv
ex_top.sv
ex_top_properties.sv
tb_ex_top.sv

/* ncpu_ex_pkg.sv */
// Execute stage shared definitions
package ncpu_ex_pkg;

   // Instruction size is 4 bytes
   localparam int NCPU_P_INSN_LEN = 2;

   // Branch opcode bus
   localparam int NCPU_BRU_IOPW = 8;

   // Conditional branches, one bit each
   localparam int NCPU_BRU_BEQ = 0;
   localparam int NCPU_BRU_BNE = 1;
   localparam int NCPU_BRU_BGTU = 2;
   localparam int NCPU_BRU_BGT = 3;
   localparam int NCPU_BRU_BLEU = 4;
   localparam int NCPU_BRU_BLE = 5;
   // Unconditional jumps
   // JMPREG takes its target from operand1
   localparam int NCPU_BRU_JMPREG = 6;
   // JMPREL is relative to the PC
   localparam int NCPU_BRU_JMPREL = 7;

   // ALU opcode bus
   localparam int NCPU_ALU_IOPW = 5;

   // ADD and SUB share the adder
   localparam int NCPU_ALU_ADD = 0;
   localparam int NCPU_ALU_SUB = 1;
   // Bitwise group
   localparam int NCPU_ALU_AND = 2;
   localparam int NCPU_ALU_OR = 3;
   localparam int NCPU_ALU_XOR = 4;

   // One-hot branch opcode
   typedef logic [NCPU_BRU_IOPW-1:0] bru_opc_t;

   // One-hot ALU opcode
   typedef logic [NCPU_ALU_IOPW-1:0] alu_opc_t;

endpackage

/* tb_ex_top.sv */
// Execute stage testbench
`timescale 1ns/1ps

module tb_ex_top
   import ncpu_ex_pkg::*;
();
   localparam int DW = 64;
   localparam int PC_W = 64 - NCPU_P_INSN_LEN;

   // One issued instruction
   typedef struct packed {
      logic             valid;
      bru_opc_t         bru;
      alu_opc_t         alu;
      logic [PC_W-1:0]  pc;
      logic [PC_W-1:0]  imm;
      logic [DW-1:0]    op1;
      logic [DW-1:0]    op2;
      logic             rf_we;
      logic [PC_W-1:0]  npc;
   } entry_t;

   logic             clk = 1'b0;
   logic             rst_n;
   entry_t           cur;
   // Stimulus table with names kept alongside
   entry_t           tbl[$];
   string            names[$];
   integer           seed;
   logic             wb_we;
   logic [DW-1:0]    wb_data;
   logic             redirect;
   logic [PC_W-1:0]  redirect_tgt;
   // Reference model outputs
   logic             exp_we;
   logic             exp_redir;
   logic [DW-1:0]    exp_data;
   logic [PC_W-1:0]  exp_tgt;
   // Equal, less and greater pairs, then -1 against 1
   logic [DW-1:0]    pair_a [4] = '{64'd5, 64'd3, 64'd9, '1};
   logic [DW-1:0]    pair_b [4] = '{64'd5, 64'd9, 64'd3, 64'd1};
   string            cond_name [6] = '{"beq", "bne", "bgtu", "bgt", "bleu", "ble"};

   always #10 clk = ~clk;

   ex_top ex_top_inst (
      .clk(clk), .rst_n(rst_n), .ex_valid(cur.valid),
      .ex_bru_opc(cur.bru), .ex_alu_opc(cur.alu), .ex_pc(cur.pc), .ex_imm(cur.imm),
      .ex_operand1(cur.op1), .ex_operand2(cur.op2), .ex_rf_we(cur.rf_we), .npc(cur.npc),
      .wb_we(wb_we), .wb_data(wb_data), .redirect(redirect), .redirect_tgt(redirect_tgt)
   );

   function automatic logic [DW-1:0] rand_word();
      rand_word = {$random(seed), $random(seed)};
   endfunction

   // Next falling edge within two clock changes
   task automatic wait_fall();
      int changes;
      changes = 0;
      do begin
         @(clk);
         changes++;
         if (changes > 2) begin
            $display("No falling clock edge within one period");
            $display("TEST FAIL");
            $fatal(1, "clock timeout");
         end
      end while (clk !== 1'b0);
   endtask

   task automatic check(input string test, input logic [DW-1:0] expected,
                        input logic [DW-1:0] actual);
      if (actual !== expected) begin
         $display("Mismatch %s expected %h actual %h", test, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // pc, imm and npc are random
   task automatic add_entry(input string name, input logic valid, input bru_opc_t bru,
                            input alu_opc_t alu, input logic [DW-1:0] op1,
                            input logic [DW-1:0] op2, input logic rf_we);
      entry_t e;
      e = entry_t'{valid, bru, alu, PC_W'(rand_word()), PC_W'(rand_word()),
                   op1, op2, rf_we, PC_W'(rand_word())};
      tbl.push_back(e);
      names.push_back(name);
   endtask

   // Expected outputs straight from the branch and ALU rules
   task automatic predict(input entry_t e);
      logic cond;
      logic jump;
      cond = (e.bru[NCPU_BRU_BEQ] && e.op1 == e.op2) ||
             (e.bru[NCPU_BRU_BNE] && e.op1 != e.op2) ||
             (e.bru[NCPU_BRU_BGTU] && e.op1 > e.op2) ||
             (e.bru[NCPU_BRU_BGT] && $signed(e.op1) > $signed(e.op2)) ||
             (e.bru[NCPU_BRU_BLEU] && e.op1 <= e.op2) ||
             (e.bru[NCPU_BRU_BLE] && $signed(e.op1) <= $signed(e.op2));
      jump = e.bru[NCPU_BRU_JMPREG] || e.bru[NCPU_BRU_JMPREL];
      exp_redir = e.valid && (cond || jump);
      exp_we = e.valid && e.rf_we;
      // Word targets
      exp_tgt = e.bru[NCPU_BRU_JMPREG] ? e.op1[DW-1:NCPU_P_INSN_LEN] :
                e.bru[NCPU_BRU_JMPREL] ? e.pc + e.op2[DW-1:NCPU_P_INSN_LEN] :
                e.pc + e.imm;
      // Link is npc as a byte address
      exp_data = (jump && e.rf_we) ? DW'(e.npc) << NCPU_P_INSN_LEN :
                 e.alu[NCPU_ALU_ADD] ? e.op1 + e.op2 :
                 e.alu[NCPU_ALU_SUB] ? e.op1 - e.op2 :
                 e.alu[NCPU_ALU_AND] ? e.op1 & e.op2 :
                 e.alu[NCPU_ALU_OR] ? e.op1 | e.op2 :
                 e.alu[NCPU_ALU_XOR] ? e.op1 ^ e.op2 : '0;
   endtask

   initial begin
      int k;
      int p;
      int pick;
      int we_pick;
      seed = 32'he3f2;
      rst_n = 1'b0;
      // Taken linking jump held at the inputs through reset
      cur = '0;
      cur.valid = 1'b1;
      cur.bru = bru_opc_t'(1) << NCPU_BRU_JMPREL;
      cur.rf_we = 1'b1;
      // Six conditions against every operand pair
      for (k = NCPU_BRU_BEQ; k <= NCPU_BRU_BLE; k++) begin
         for (p = 0; p < 4; p++) begin
            add_entry($sformatf("%s_pair%0d", cond_name[k], p), 1'b1, bru_opc_t'(1) << k,
                      '0, pair_a[p], pair_b[p], 1'b0);
         end
      end
      add_entry("jmprel_link", 1'b1, bru_opc_t'(1) << NCPU_BRU_JMPREL, '0,
                rand_word(), rand_word(), 1'b1);
      add_entry("jmpreg_link", 1'b1, bru_opc_t'(1) << NCPU_BRU_JMPREG, '0,
                rand_word(), rand_word(), 1'b1);
      add_entry("jmprel_nolink", 1'b1, bru_opc_t'(1) << NCPU_BRU_JMPREL, '0,
                rand_word(), rand_word(), 1'b0);
      add_entry("add", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_ADD, 64'd40, 64'd2, 1'b1);
      add_entry("sub", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_SUB, 64'd40, 64'd2, 1'b1);
      add_entry("sub_wrap", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_SUB, 64'd0, 64'd1, 1'b1);
      add_entry("and", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_AND, 64'hF0F0, 64'h0FF0, 1'b1);
      add_entry("or", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_OR, 64'hF0F0, 64'h0FF0, 1'b1);
      add_entry("xor", 1'b1, '0, alu_opc_t'(1) << NCPU_ALU_XOR, 64'hF0F0, 64'h0FF0, 1'b1);
      // Would be taken if valid
      add_entry("no_valid", 1'b0, bru_opc_t'(1) << NCPU_BRU_BEQ, '0, 64'd7, 64'd7, 1'b1);
      // Random mix issued back to back
      for (k = 0; k < 16; k++) begin
         pick = {$random(seed)} % 13;
         we_pick = {$random(seed)} % 2;
         add_entry($sformatf("rand%0d", k), 1'b1,
                   (pick < 8) ? bru_opc_t'(1) << pick : '0,
                   (pick < 8) ? '0 : alu_opc_t'(1) << (pick - 8),
                   rand_word(), rand_word(), we_pick[0]);
      end
      // Five reset cycles, then the held jump dropped to not valid
      for (k = 0; k < 6; k++) begin
         if (k == 5) begin
            rst_n = 1'b1;
            cur.valid = 1'b0;
         end
         wait_fall();
         check($sformatf("reset%0d wb_we", k), '0, DW'(wb_we));
         check($sformatf("reset%0d redirect", k), '0, DW'(redirect));
      end
      foreach (tbl[i]) begin
         cur = tbl[i];
         wait_fall();
         predict(tbl[i]);
         check({names[i], " wb_we"}, DW'(exp_we), DW'(wb_we));
         check({names[i], " redirect"}, DW'(exp_redir), DW'(redirect));
         if (exp_we)
            check({names[i], " wb_data"}, exp_data, wb_data);
         if (exp_redir)
            check({names[i], " redirect_tgt"}, DW'(exp_tgt), DW'(redirect_tgt));
      end
      $display("TEST PASS");
      $finish;
   end

endmodule
